/* rtl/video_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types, register numbers and reset values of the video
// generator. Modules refer to them by package-scoped names.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package video_pkg;

typedef logic [15:0] word_t;                    // register or vram word
typedef logic [15:0] addr_t;                    // vram word address
typedef logic [7:0]  color_t;                   // palette index
typedef logic [3:0]  reg_num_t;                 // config register number

// video control registers
localparam reg_num_t XR_VID_CTRL     = 4'd0;    // border colour in [7:0]
localparam reg_num_t XR_VID_INTR     = 4'd1;    // write forces an interrupt
localparam reg_num_t XR_VID_LEFT     = 4'd2;    // first non-border column
localparam reg_num_t XR_VID_RIGHT    = 4'd3;    // first right border column
localparam reg_num_t XR_SCANLINE     = 4'd4;    // read only, vertical count
localparam reg_num_t XR_VID_HSIZE    = 4'd5;    // read only, visible width
localparam reg_num_t XR_VID_VSIZE    = 4'd6;    // read only, visible height

// playfield registers
localparam reg_num_t XR_PF_GFX_CTRL  = 4'd8;    // colorbase [15:8], blank [7], bpp8 [4]
localparam reg_num_t XR_PF_DISP_ADDR = 4'd9;    // display start address
localparam reg_num_t XR_PF_LINE_LEN  = 4'd10;   // words per line

localparam color_t BORDER_RESET   = 8'h08;      // dark grey, shows the design is alive
localparam word_t  LINE_LEN_RESET = 16'd16;

endpackage

`default_nettype wire

/* rtl/video_timing.sv */
//////////////////////////////////////////////////////////////////////
// Horizontal and vertical raster counters. Each line and each frame
// runs front porch, sync, back porch, then the visible part.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output logic [15:0]         h_count_o,
    output logic [15:0]         v_count_o,
    output logic                h_visible_o,
    output logic                v_visible_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                end_of_line_o,
    output logic                end_of_visible_o
);

localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;
localparam int V_OFF   = V_FRONT + V_SYNC + V_BACK;
localparam int H_TOTAL = H_OFF + H_VISIBLE;
localparam int V_TOTAL = V_OFF + V_VISIBLE;

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o <= '0;
        v_count_o <= '0;
    end else if (end_of_line_o) begin
        h_count_o <= '0;
        v_count_o <= end_of_visible_o ? 16'd0 : v_count_o + 16'd1;
    end else begin
        h_count_o <= h_count_o + 16'd1;
    end
end

assign end_of_line_o    = (h_count_o == 16'(H_TOTAL - 1));
assign end_of_visible_o = end_of_line_o && (v_count_o == 16'(V_TOTAL - 1));  // visible is last

assign hsync_o     = (h_count_o >= 16'(H_FRONT)) && (h_count_o < 16'(H_FRONT + H_SYNC));
assign vsync_o     = (v_count_o >= 16'(V_FRONT)) && (v_count_o < 16'(V_FRONT + V_SYNC));
assign h_visible_o = (h_count_o >= 16'(H_OFF));
assign v_visible_o = (v_count_o >= 16'(V_OFF));

endmodule

`default_nettype wire

/* rtl/video_regs.sv */
//////////////////////////////////////////////////////////////////////
// Video configuration registers. Writes land at the next clock edge,
// read data follows the register number by one cycle.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire video_pkg::word_t   reg_data_i,
    input  wire logic [15:0]        v_count_i,
    input  wire logic               end_of_visible_i,
    output video_pkg::word_t        reg_data_o,
    output logic                    intr_o,
    output video_pkg::color_t       border_color_o,
    output video_pkg::word_t        vid_left_o,
    output video_pkg::word_t        vid_right_o,
    output video_pkg::color_t       pf_colorbase_o,
    output logic                    pf_blank_o,
    output logic                    pf_bpp8_o,
    output video_pkg::addr_t        pf_start_addr_o,
    output video_pkg::word_t        pf_line_len_o
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_o          <= 1'b0;
        border_color_o  <= video_pkg::BORDER_RESET;
        vid_left_o      <= '0;
        vid_right_o     <= 16'(H_VISIBLE);
        pf_colorbase_o  <= '0;
        pf_blank_o      <= 1'b1;            // playfield off until software sets it up
        pf_bpp8_o       <= 1'b0;
        pf_start_addr_o <= '0;
        pf_line_len_o   <= video_pkg::LINE_LEN_RESET;
    end else begin
        intr_o <= end_of_visible_i;         // one pulse per frame
        if (reg_wr_i) begin
            case (reg_num_i)
                video_pkg::XR_VID_CTRL: begin
                    border_color_o <= reg_data_i[7:0];
                end
                video_pkg::XR_VID_INTR: begin
                    intr_o <= 1'b1;         // software forced pulse
                end
                video_pkg::XR_VID_LEFT: begin
                    vid_left_o <= reg_data_i;
                end
                video_pkg::XR_VID_RIGHT: begin
                    vid_right_o <= reg_data_i;
                end
                video_pkg::XR_PF_GFX_CTRL: begin
                    pf_colorbase_o <= reg_data_i[15:8];
                    pf_blank_o     <= reg_data_i[7];
                    pf_bpp8_o      <= reg_data_i[4];
                end
                video_pkg::XR_PF_DISP_ADDR: begin
                    pf_start_addr_o <= reg_data_i;
                end
                video_pkg::XR_PF_LINE_LEN: begin
                    pf_line_len_o <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end
end

// registered read-back
always_ff @(posedge clk) begin
    case (reg_num_i)
        video_pkg::XR_VID_CTRL:     reg_data_o <= {8'h00, border_color_o};
        video_pkg::XR_VID_LEFT:     reg_data_o <= vid_left_o;
        video_pkg::XR_VID_RIGHT:    reg_data_o <= vid_right_o;
        video_pkg::XR_SCANLINE:     reg_data_o <= v_count_i;
        video_pkg::XR_VID_HSIZE:    reg_data_o <= 16'(H_VISIBLE);
        video_pkg::XR_VID_VSIZE:    reg_data_o <= 16'(V_VISIBLE);
        video_pkg::XR_PF_GFX_CTRL:  reg_data_o <= {pf_colorbase_o, pf_blank_o, 2'b00,
                                                   pf_bpp8_o, 4'h0};
        video_pkg::XR_PF_DISP_ADDR: reg_data_o <= pf_start_addr_o;
        video_pkg::XR_PF_LINE_LEN:  reg_data_o <= pf_line_len_o;
        default:                    reg_data_o <= '0;   // XR_VID_INTR and unused numbers
    endcase
end

endmodule

`default_nettype wire

/* rtl/video_playfield.sv */
//////////////////////////////////////////////////////////////////////
// Bitmap playfield. Fetches display words from VRAM ahead of the
// visible columns and shifts them out as 4 or 8 bit palette indices,
// with the raster signals delayed to line up with the pixels.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_playfield #(
    parameter int H_VISIBLE = 640,
    parameter int PREFETCH  = 2
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [15:0]        h_count_i,
    input  wire logic               h_visible_i,
    input  wire logic               v_visible_i,
    input  wire logic               hsync_i,
    input  wire logic               vsync_i,
    input  wire logic               end_of_line_i,
    input  wire logic               intr_i,
    input  wire video_pkg::color_t  pf_colorbase_i,
    input  wire logic               pf_blank_i,
    input  wire logic               pf_bpp8_i,
    input  wire video_pkg::addr_t   pf_start_addr_i,
    input  wire video_pkg::word_t   pf_line_len_i,
    input  wire video_pkg::word_t   vid_left_i,
    input  wire video_pkg::word_t   vid_right_i,
    input  wire video_pkg::color_t  border_color_i,
    input  wire video_pkg::word_t   vram_data_i,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    output video_pkg::color_t       color_index_o,
    output logic                    dv_de_o,
    output logic                    h_blank_o,
    output logic                    v_blank_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    intr_o
);

// fetch to pixel takes 4 cycles, so PREFETCH may be 0 to 2
localparam int DLY = 4 - PREFETCH;

logic [15:0]        h_last;                 // last count of a line
logic [15:0]        vis_first;              // count of the first visible column
logic [15:0]        col;                    // visible column of h_count_i
logic               fetch_start;
logic               fetch;
logic               win;                    // fetch window, open until end of line
logic [1:0]         phase;                  // cycle within the current word
video_pkg::addr_t   line_addr;
logic               rd_valid;               // vram_data_i holds a fetched word
video_pkg::word_t   shift;
video_pkg::color_t  pixel;
logic               border;
logic [5:0]         pipe_in;
logic [5:0]         pipe [DLY-1];           // raster signals waiting for their pixels
logic [5:0]         pipe_out;

assign vis_first   = h_last - 16'(H_VISIBLE - 1);
assign col         = h_count_i - vis_first;
assign fetch_start = v_visible_i & ~pf_blank_i & (h_count_i == vis_first - 16'(PREFETCH));
assign fetch       = ~pf_blank_i & (fetch_start | (win & (phase == 2'd0)));
assign pixel       = pf_bpp8_i ? shift[15:8] : {4'h0, shift[15:12]};  // msb first
assign border      = (col < vid_left_i) | (col >= vid_right_i);
assign pipe_in     = {border, h_visible_i, v_visible_i, hsync_i, vsync_i, intr_i};
assign pipe_out    = pipe[DLY-2];

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_last     <= '0;
        win        <= 1'b0;
        phase      <= 2'd0;
        vram_sel_o <= 1'b0;
        rd_valid   <= 1'b0;
    end else begin
        if (end_of_line_i) begin
            h_last <= h_count_i;
            win    <= 1'b0;
        end else if (fetch_start) begin
            win    <= 1'b1;
        end
        if (fetch_start) begin
            phase <= 2'd1;
        end else if (win) begin
            phase <= pf_bpp8_i ? {1'b0, ~phase[0]} : phase + 2'd1;  // 2 or 4 pixels a word
        end
        vram_sel_o <= fetch;
        rd_valid   <= vram_sel_o;               // memory answers one cycle after select
    end
end

always_ff @(posedge clk) begin
    if (end_of_line_i) begin
        // holds the start address until the first visible line
        line_addr <= v_visible_i ? line_addr + pf_line_len_i : pf_start_addr_i;
    end
    if (fetch) begin
        vram_addr_o <= fetch_start ? line_addr : vram_addr_o + 16'd1;
    end
    if (rd_valid) begin
        shift <= vram_data_i;
    end else begin
        shift <= pf_bpp8_i ? {shift[7:0], 8'h00} : {shift[11:0], 4'h0};
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < DLY - 1; i++) begin
            pipe[i] <= '0;
        end
    end else begin
        pipe[0] <= pipe_in;
        for (int i = 1; i < DLY - 1; i++) begin
            pipe[i] <= pipe[i - 1];
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        color_index_o <= '0;
        dv_de_o       <= 1'b0;
        h_blank_o     <= 1'b1;
        v_blank_o     <= 1'b1;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        intr_o        <= 1'b0;
    end else begin
        // border colour bypasses colorbase
        color_index_o <= (pipe_out[5] | pf_blank_i) ? border_color_i : pixel ^ pf_colorbase_i;
        dv_de_o       <= pipe_out[4] & pipe_out[3];
        h_blank_o     <= ~pipe_out[4];
        v_blank_o     <= ~pipe_out[3];
        hsync_o       <= pipe_out[2];
        vsync_o       <= pipe_out[1];
        intr_o        <= pipe_out[0];
    end
end

endmodule

`default_nettype wire

/* rtl/video_gen.sv */
//////////////////////////////////////////////////////////////////////
// Video generator top level. Ties the raster timing, the register
// file and the bitmap playfield together; VRAM sits outside.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_gen #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int PREFETCH  = 2
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire video_pkg::word_t   reg_data_i,
    input  wire video_pkg::word_t   vram_data_i,
    output video_pkg::word_t        reg_data_o,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    output video_pkg::color_t       color_index_o,
    output logic                    dv_de_o,
    output logic                    h_blank_o,
    output logic                    v_blank_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    video_intr_o
);

logic [15:0]        h_count;
logic [15:0]        v_count;
logic               h_visible;
logic               v_visible;
logic               hsync;
logic               vsync;
logic               end_of_line;
logic               end_of_visible;
logic               intr;                   // raw pulse, before pixel alignment
video_pkg::color_t  border_color;
video_pkg::word_t   vid_left;
video_pkg::word_t   vid_right;
video_pkg::color_t  pf_colorbase;
logic               pf_blank;
logic               pf_bpp8;
video_pkg::addr_t   pf_start_addr;
video_pkg::word_t   pf_line_len;

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) timing (
    .clk(clk), .reset_i(reset_i),
    .h_count_o(h_count), .v_count_o(v_count),
    .h_visible_o(h_visible), .v_visible_o(v_visible),
    .hsync_o(hsync), .vsync_o(vsync),
    .end_of_line_o(end_of_line), .end_of_visible_o(end_of_visible)
);

video_regs #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) regs (
    .clk(clk), .reset_i(reset_i),
    .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
    .v_count_i(v_count), .end_of_visible_i(end_of_visible),
    .reg_data_o(reg_data_o), .intr_o(intr), .border_color_o(border_color),
    .vid_left_o(vid_left), .vid_right_o(vid_right),
    .pf_colorbase_o(pf_colorbase), .pf_blank_o(pf_blank), .pf_bpp8_o(pf_bpp8),
    .pf_start_addr_o(pf_start_addr), .pf_line_len_o(pf_line_len)
);

video_playfield #(.H_VISIBLE(H_VISIBLE), .PREFETCH(PREFETCH)) playfield (
    .clk(clk), .reset_i(reset_i),
    .h_count_i(h_count), .h_visible_i(h_visible), .v_visible_i(v_visible),
    .hsync_i(hsync), .vsync_i(vsync), .end_of_line_i(end_of_line), .intr_i(intr),
    .pf_colorbase_i(pf_colorbase), .pf_blank_i(pf_blank), .pf_bpp8_i(pf_bpp8),
    .pf_start_addr_i(pf_start_addr), .pf_line_len_i(pf_line_len),
    .vid_left_i(vid_left), .vid_right_i(vid_right), .border_color_i(border_color),
    .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
    .color_index_o(color_index_o), .dv_de_o(dv_de_o),
    .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .intr_o(video_intr_o)
);

endmodule

`default_nettype wire

/* include/tb_compare.svh */
//////////////////////////////////////////////////////////////////////
// Result compare tasks for the video generator testbench. Included
// inside the testbench module; the first mismatch ends the run.
//////////////////////////////////////////////////////////////////////
`ifndef TB_COMPARE_SVH
`define TB_COMPARE_SVH

task automatic report_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL %s got %h expected %h", name, got, exp);
    $display("SIMULATION FAILED");
    $fatal(1, "mismatch on %s", name);
endtask

// register read-back
task automatic compare_word(input string name, input video_pkg::word_t got,
                            input video_pkg::word_t exp);
    if (got !== exp) begin
        report_fail(name, 32'(got), 32'(exp));
    end
endtask

// one pixel against the reference model
task automatic compare_color(input string name, input video_pkg::color_t got,
                             input video_pkg::color_t exp);
    if (got !== exp) begin
        report_fail(name, 32'(got), 32'(exp));
    end
endtask

// interrupt pulses counted over a frame
task automatic compare_intr(input string name, input int got, input int exp);
    if (got != exp) begin
        report_fail(name, 32'(got), 32'(exp));
    end
endtask

// single blank, sync or enable flag
task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_fail(name, 32'(got), 32'(exp));
    end
endtask

`endif

/* sim/video_gen_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the video generator. Runs the command list from the
// golden file and checks read-back, pixels, blanking and interrupts
// against a reference model fed from the same VRAM contents.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_gen_tb;

localparam int H_VISIBLE    = 32;
localparam int H_PORCH      = 4;                // front, sync and back each
localparam int V_VISIBLE    = 4;
localparam int V_PORCH      = 1;
localparam int H_TOTAL      = H_VISIBLE + 3 * H_PORCH;
localparam int V_TOTAL      = V_VISIBLE + 3 * V_PORCH;
localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

logic                   clk;
logic                   reset_i;
logic                   reg_wr_i;
video_pkg::reg_num_t    reg_num_i;
video_pkg::word_t       reg_data_i;
video_pkg::word_t       vram_data_i;
video_pkg::word_t       reg_data_o;
logic                   vram_sel_o;
video_pkg::addr_t       vram_addr_o;
video_pkg::color_t      color_index_o;
logic                   dv_de_o;
logic                   h_blank_o;
logic                   v_blank_o;
logic                   hsync_o;
logic                   vsync_o;
logic                   video_intr_o;

video_pkg::word_t       vram [0:65535];
integer                 seed;
logic                   vram_rd;                // select seen in the previous cycle
video_pkg::addr_t       vram_rd_addr;

// software view of the configuration registers
video_pkg::color_t      cfg_border;
video_pkg::word_t       cfg_left;
video_pkg::word_t       cfg_right;
video_pkg::color_t      cfg_colorbase;
logic                   cfg_blank;
logic                   cfg_bpp8;
video_pkg::addr_t       cfg_start;
video_pkg::word_t       cfg_len;

byte                    ops [$];
int                     nums [$];
int                     vals [$];
int                     frames_total;
int                     watchdog_cycles;
logic                   check_en;               // pixel checks during run frames only
logic                   prev_dv;
logic                   prev_vb;
int                     pix_x;
int                     line_y;
int                     frame_count;
int                     intr_count;
int                     forced_intr;
logic                   raster_locked;          // output raster position is known
int                     out_h;                  // output column, 0 is the first front porch cycle
int                     out_v;                  // output line, 0 is the front porch line

`include "tb_compare.svh"

video_gen #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_PORCH), .H_SYNC(H_PORCH), .H_BACK(H_PORCH),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_PORCH), .V_SYNC(V_PORCH), .V_BACK(V_PORCH),
    .PREFETCH(2)
) uut (
    .clk(clk), .reset_i(reset_i),
    .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
    .vram_data_i(vram_data_i), .reg_data_o(reg_data_o),
    .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
    .color_index_o(color_index_o), .dv_de_o(dv_de_o),
    .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .video_intr_o(video_intr_o)
);

always #20 clk = ~clk;

task automatic abort_run(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", what);
endtask

// vram answers one cycle after the select
always @(negedge clk) begin
    vram_rd      <= vram_sel_o;
    vram_rd_addr <= vram_addr_o;
end

always @(posedge clk) begin
    #2;
    if (vram_rd) begin
        vram_data_i = vram[vram_rd_addr];
    end
end

function automatic video_pkg::color_t expected_pixel(input int x, input int y);
    video_pkg::word_t   word;
    video_pkg::color_t  pix;
    if (x < cfg_left || x >= cfg_right || cfg_blank) begin
        return cfg_border;                      // border skips colorbase
    end
    if (cfg_bpp8) begin
        word = vram[16'(cfg_start + y * cfg_len + x / 2)];
        pix  = (x % 2 == 0) ? word[15:8] : word[7:0];
    end else begin
        word = vram[16'(cfg_start + y * cfg_len + x / 4)];
        pix  = {4'h0, word[15 - 4 * (x % 4) -: 4]};
    end
    return pix ^ cfg_colorbase;
endfunction

// blanking, sync and enable against the raster position of the outputs
task automatic check_raster();
    logic hb;
    logic vb;
    hb = (out_h < 3 * H_PORCH);
    vb = (out_v < 3 * V_PORCH);
    compare_bit("h_blank_o", h_blank_o, hb);
    compare_bit("v_blank_o", v_blank_o, vb);
    compare_bit("hsync_o", hsync_o, (out_h >= H_PORCH) && (out_h < 2 * H_PORCH));
    compare_bit("vsync_o", vsync_o, (out_v >= V_PORCH) && (out_v < 2 * V_PORCH));
    compare_bit("dv_de_o", dv_de_o, !hb && !vb);
endtask

task automatic load_golden();
    int     fd;
    int     n;
    int     num;
    int     val;
    byte    op;
    string  line;
    fd = $fopen("sim/video_gen_golden.txt", "r");
    if (fd == 0) begin
        abort_run("cannot open the golden command file");
    end
    while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line[0] == "#") begin
            continue;                           // blank or comment line
        end
        n = $sscanf(line, "%c %h %h", op, num, val);
        if (n != 3 || !(op == "W" || op == "R" || op == "F")) begin
            abort_run($sformatf("malformed golden line: %s", line));
        end
        ops.push_back(op);
        nums.push_back(num);
        vals.push_back(val);
        if (op == "F") begin
            frames_total += val + 2;            // plus a partial frame and the sync frame
        end
    end
    $fclose(fd);
    watchdog_cycles = 16 + 4 * ops.size() + 2 * FRAME_CYCLES * frames_total;
endtask

task automatic write_reg(input video_pkg::reg_num_t num, input video_pkg::word_t data);
    @(posedge clk);
    #2;
    reg_wr_i   = 1'b1;
    reg_num_i  = num;
    reg_data_i = data;
    @(posedge clk);                             // write lands here
    #2;
    reg_wr_i = 1'b0;
    case (num)
        4'd0: cfg_border = data[7:0];
        4'd1: forced_intr++;
        4'd2: cfg_left = data;
        4'd3: cfg_right = data;
        4'd8: begin
            cfg_colorbase = data[15:8];
            cfg_blank     = data[7];
            cfg_bpp8      = data[4];
        end
        4'd9: cfg_start = data;
        4'd10: cfg_len = data;
        default: begin
        end
    endcase
endtask

task automatic read_reg(input video_pkg::reg_num_t num, input video_pkg::word_t exp);
    @(posedge clk);
    #2;
    reg_num_i = num;
    @(posedge clk);
    @(negedge clk);
    if (num == 4'd4) begin
        if (reg_data_o >= V_TOTAL) begin
            abort_run($sformatf("FAIL reg_data_o[4] got %h, expected below %h",
                                reg_data_o, 16'(V_TOTAL)));
        end
    end else begin
        compare_word($sformatf("reg_data_o[%0h]", num), reg_data_o, exp);
    end
endtask

task automatic run_frames(input int n);
    int first;
    first = frame_count + 1;
    wait (frame_count == first);                // skip the frame in progress
    check_en = 1'b1;
    wait (frame_count == first + n);
    check_en = 1'b0;
    compare_intr("video_intr_o pulse count", intr_count, frame_count + forced_intr);
endtask

// output monitor, sampled away from the rising edge
always @(negedge clk) begin
    if (!reset_i) begin
        if (raster_locked) begin
            out_h++;
            if (out_h == H_TOTAL) begin
                out_h = 0;
                out_v = (out_v + 1) % V_TOTAL;
            end
            check_raster();
        end else if (prev_vb && !v_blank_o) begin
            raster_locked = 1'b1;               // first visible line opens with its front porch
            out_h         = 0;
            out_v         = 3 * V_PORCH;
        end
        if (video_intr_o) begin
            intr_count++;
        end
        if (dv_de_o) begin
            if (check_en) begin
                compare_color("color_index_o", color_index_o, expected_pixel(pix_x, line_y));
            end
            pix_x++;
        end else if (prev_dv) begin
            if (check_en && pix_x != H_VISIBLE) begin
                abort_run($sformatf("line %0d carried %0d pixels", line_y, pix_x));
            end
            pix_x = 0;
            line_y++;
        end
        if (v_blank_o && !prev_vb) begin        // end of the visible frame
            if (check_en && line_y != V_VISIBLE) begin
                abort_run($sformatf("frame carried %0d visible lines", line_y));
            end
            if (!prev_dv) begin
                abort_run("frame ended without a pixel in the cycle before");
            end
            compare_intr("video_intr_o", int'(video_intr_o), 1);
            line_y = 0;
            frame_count++;
        end
        if (check_en && cfg_blank && vram_sel_o) begin
            abort_run("vram_sel_o went high while the playfield was blanked");
        end
        prev_dv = dv_de_o;
        prev_vb = v_blank_o;
    end
end

initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("timeout, commands still running after %0d cycles", watchdog_cycles));
end

initial begin
    clk         = 1'b0;
    reset_i     = 1'b1;
    reg_wr_i    = 1'b0;
    reg_num_i   = '0;
    reg_data_i  = '0;
    vram_data_i = '0;
    check_en    = 1'b0;
    prev_dv     = 1'b0;
    prev_vb     = 1'b1;
    pix_x       = 0;
    line_y      = 0;
    frame_count = 0;
    intr_count  = 0;
    forced_intr = 0;
    raster_locked = 1'b0;
    out_h         = 0;
    out_v         = 0;
    frames_total    = 0;
    watchdog_cycles = 0;
    cfg_border    = 8'h08;
    cfg_left      = 16'd0;
    cfg_right     = 16'(H_VISIBLE);
    cfg_colorbase = 8'h00;
    cfg_blank     = 1'b1;
    cfg_bpp8      = 1'b0;
    cfg_start     = 16'h0000;
    cfg_len       = 16'd16;
    seed = 32'hdc56;
    for (int a = 0; a < 65536; a++) begin
        vram[a] = 16'($random(seed));
    end
    load_golden();
    repeat (16) @(posedge clk);
    #2;
    reset_i = 1'b0;
    foreach (ops[i]) begin
        case (ops[i])
            "W": write_reg(4'(nums[i]), 16'(vals[i]));
            "R": read_reg(4'(nums[i]), 16'(vals[i]));
            default: run_frames(vals[i]);
        endcase
    end
    $display("SIMULATION PASSED");
    $finish;
end

endmodule

`default_nettype wire

/* sim/video_gen_golden.txt */
# op reg value, all hex: W writes value, R expects value (scanline is range checked)
# F runs value frames with pixel checks, its reg column is unused
R 0 0008
R 1 0000
R 2 0000
R 3 0020
R 4 0000
R 5 0020
R 6 0004
R 7 0000
R 8 0080
R 9 0000
R A 0010
R F 0000
W 8 0000
W 9 0040
R 9 0040
F 0 0002
W 0 0025
W 2 0004
W 3 001C
W 8 5A10
W A 0014
R 0 0025
R 3 001C
R 8 5A10
R A 0014
F 0 0002
W 1 0000
W 8 3390
R 8 3390
F 0 0001
R 4 0000

/* list.f */
+incdir+include
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/video_playfield.sv
rtl/video_gen.sv
sim/video_gen_tb.sv

/* Bender.yml */
package:
  name: video_gen
  description: "Raster video generator with a bitmap playfield"

sources:
  - files:
      - rtl/video_pkg.sv
      - rtl/video_timing.sv
      - rtl/video_regs.sv
      - rtl/video_playfield.sv
      - rtl/video_gen.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/video_gen_tb.sv
